/* conv_pkg.sv */
package conv_pkg;

  //////////////////////////////
  // Data widths
  //////////////////////////////

  localparam int DATA_WIDTH = 16;
  // Eight guard bits cover up to 256 channels
  localparam int SUM_WIDTH = DATA_WIDTH + 8;

  typedef logic signed [DATA_WIDTH-1:0] pixel_t;
  typedef logic signed [SUM_WIDTH-1:0]  sum_t;

  // Pixel index caps a frame at 4096 pixels
  typedef logic [11:0] pixel_idx_t;
  typedef logic [7:0]  channel_idx_t;

  //////////////////////////////
  // Pipeline structs
  //////////////////////////////

  // Position tag that follows a pixel down the pipeline
  typedef struct packed {
    pixel_idx_t pixel_idx;
    logic       first_channel;
    logic       last_channel;
  } beat_tag_t;

  // Registered FIFO read output
  typedef struct packed {
    logic   valid;
    pixel_t data;
  } pixel_beat_t;

  // Read burst sequencer
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_BURST, SEQ_GAP} seq_state_t;

endpackage

/* frame_fifo.sv */
module frame_fifo #(
  parameter int IMAGE_SIZE = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wr_en,
  input  conv_pkg::pixel_t     din,
  input  logic                 rd_en,
  output conv_pkg::pixel_beat_t rd_beat,
  output conv_pkg::pixel_idx_t count
);
  import conv_pkg::*;

  localparam int DEPTH  = 2 * IMAGE_SIZE;
  localparam int ADDR_W = $clog2(DEPTH);

  pixel_t             mem [DEPTH];
  logic [ADDR_W-1:0]  wr_ptr;
  logic [ADDR_W-1:0]  rd_ptr;
  pixel_idx_t         count_q;
  logic               full;
  logic               empty;
  logic               wr_ok;
  logic               rd_ok;
  logic               rd_valid_q;
  pixel_t             rd_data_q;

  assign full  = (count_q == pixel_idx_t'(DEPTH));
  assign empty = (count_q == '0);
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + ADDR_W'(1);
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + ADDR_W'(1);
      end
      case ({wr_ok, rd_ok})
        2'b10:   count_q <= count_q + pixel_idx_t'(1);
        2'b01:   count_q <= count_q - pixel_idx_t'(1);
        default: count_q <= count_q;
      endcase
      rd_valid_q <= rd_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
    if (rd_ok) begin
      rd_data_q <= mem[rd_ptr];
    end
  end

  assign rd_beat = '{valid: rd_valid_q, data: rd_data_q};
  assign count   = count_q;

endmodule

/* psum_buffer.sv */
module psum_buffer #(
  parameter int IMAGE_SIZE = 16
) (
  input  logic                 clk,
  input  conv_pkg::pixel_idx_t rd_addr,
  output conv_pkg::sum_t       rd_data,
  input  logic                 wr_en,
  input  conv_pkg::pixel_idx_t wr_addr,
  input  conv_pkg::sum_t       wr_data
);
  import conv_pkg::*;

  localparam int ADDR_W = $clog2(IMAGE_SIZE);

  sum_t              mem [IMAGE_SIZE];
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W-1:0] wr_ptr;

  // Indices never exceed IMAGE_SIZE-1, so the low bits suffice
  assign rd_ptr = rd_addr[ADDR_W-1:0];
  assign wr_ptr = wr_addr[ADDR_W-1:0];

  // Write-back lands two cycles after the read of the same location
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_ptr];
  end

endmodule

/* pixel_channel_counter.sv */
module pixel_channel_counter #(
  parameter int IMAGE_SIZE  = 16,
  parameter int CHANNEL_NUM = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                advance,
  output conv_pkg::beat_tag_t tag
);
  import conv_pkg::*;

  pixel_idx_t   pixel_q;
  channel_idx_t channel_q;
  logic         pixel_wrap;
  logic         channel_wrap;

  assign pixel_wrap   = (pixel_q == pixel_idx_t'(IMAGE_SIZE - 1));
  assign channel_wrap = (channel_q == channel_idx_t'(CHANNEL_NUM - 1));

  //////////////////////////////
  // Pixel and channel counting
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_q   <= '0;
      channel_q <= '0;
    end else if (advance) begin
      if (pixel_wrap) begin
        pixel_q <= '0;
        // Channel steps once per finished frame
        if (channel_wrap) begin
          channel_q <= '0;
        end else begin
          channel_q <= channel_q + channel_idx_t'(1);
        end
      end else begin
        pixel_q <= pixel_q + pixel_idx_t'(1);
      end
    end
  end

  // Flags for the zero select and the output gate
  always_comb begin
    tag.pixel_idx     = pixel_q;
    tag.first_channel = (channel_q == '0);
    tag.last_channel  = channel_wrap;
  end

endmodule

/* channel_sequencer.sv */
module channel_sequencer #(
  parameter int IMAGE_SIZE = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  conv_pkg::pixel_idx_t count,
  input  conv_pkg::beat_tag_t  cur_tag,
  output logic                 rd_en,
  output logic                 advance,
  output conv_pkg::beat_tag_t  rd_tag
);
  import conv_pkg::*;

  seq_state_t state;
  seq_state_t state_next;
  logic       frame_ready;
  logic       burst_done;

  // A whole frame sits in the FIFO
  assign frame_ready = (count >= pixel_idx_t'(IMAGE_SIZE));
  // The counter shows the last pixel on the final read of a burst
  assign burst_done  = (cur_tag.pixel_idx == pixel_idx_t'(IMAGE_SIZE - 1));

  //////////////////////////////
  // Burst FSM
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      SEQ_IDLE: begin
        if (frame_ready) begin
          state_next = SEQ_BURST;
        end
      end
      SEQ_BURST: begin
        if (burst_done) begin
          state_next = SEQ_GAP;
        end
      end
      SEQ_GAP: begin
        state_next = SEQ_IDLE;
      end
      default: begin
        state_next = SEQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SEQ_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // One FIFO read and one counter step per burst cycle
  assign rd_en   = (state == SEQ_BURST);
  assign advance = rd_en;

  // Tag lines up with the FIFO data one cycle later
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tag <= cur_tag;
    end
  end

endmodule

/* channel_accumulator.sv */
module channel_accumulator (
  input  logic                  clk,
  input  logic                  reset,
  input  conv_pkg::pixel_beat_t pix_beat,
  input  conv_pkg::beat_tag_t   tag,
  input  conv_pkg::sum_t        stored_sum,
  output logic                  wr_en,
  output conv_pkg::pixel_idx_t  wr_addr,
  output conv_pkg::sum_t        wr_data,
  output logic                  valid_out,
  output conv_pkg::sum_t        pxl_out
);
  import conv_pkg::*;

  sum_t       pixel_ext;
  sum_t       addend;
  sum_t       sum_next;
  logic       valid_q;
  logic       last_q;
  pixel_idx_t addr_q;
  sum_t       sum_q;

  //////////////////////////////
  // Add stage
  //////////////////////////////

  // Sign extension into the guard bits
  assign pixel_ext = {{(SUM_WIDTH - DATA_WIDTH){pix_beat.data[DATA_WIDTH-1]}},
                      pix_beat.data};

  // First channel of a group starts from zero
  assign addend   = tag.first_channel ? '0 : stored_sum;
  assign sum_next = pixel_ext + addend;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= pix_beat.valid;
      last_q  <= pix_beat.valid && tag.last_channel;
    end
  end

  always_ff @(posedge clk) begin
    if (pix_beat.valid) begin
      addr_q <= tag.pixel_idx;
      sum_q  <= sum_next;
    end
  end

  // Write-back of every beat
  assign wr_en   = valid_q;
  assign wr_addr = addr_q;
  assign wr_data = sum_q;

  // Only the last channel of a group leaves the block
  assign valid_out = last_q;
  assign pxl_out   = valid_out ? sum_q : '0;

endmodule

/* channel_in_adder.sv */
module channel_in_adder #(
  parameter int IMAGE_SIZE  = 16,
  parameter int CHANNEL_NUM = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             valid_in,
  input  conv_pkg::pixel_t pxl_in,
  output logic             valid_out,
  output conv_pkg::sum_t   pxl_out
);
  import conv_pkg::*;

  pixel_idx_t  fifo_count;
  pixel_beat_t rd_beat;
  beat_tag_t   cur_tag;
  beat_tag_t   rd_tag;
  logic        rd_en;
  logic        advance;
  sum_t        stored_sum;
  logic        wb_en;
  pixel_idx_t  wb_addr;
  sum_t        wb_data;

  //////////////////////////////
  // Input side
  //////////////////////////////

  frame_fifo #(.IMAGE_SIZE(IMAGE_SIZE)) fifo_i (
    .clk    (clk),
    .reset  (reset),
    .wr_en  (valid_in),
    .din    (pxl_in),
    .rd_en  (rd_en),
    .rd_beat(rd_beat),
    .count  (fifo_count)
  );

  pixel_channel_counter #(
    .IMAGE_SIZE (IMAGE_SIZE),
    .CHANNEL_NUM(CHANNEL_NUM)
  ) counter_i (
    .clk    (clk),
    .reset  (reset),
    .advance(advance),
    .tag    (cur_tag)
  );

  channel_sequencer #(.IMAGE_SIZE(IMAGE_SIZE)) seq_i (
    .clk    (clk),
    .reset  (reset),
    .count  (fifo_count),
    .cur_tag(cur_tag),
    .rd_en  (rd_en),
    .advance(advance),
    .rd_tag (rd_tag)
  );

  //////////////////////////////
  // Sum side
  //////////////////////////////

  // Read address comes straight from the counter in the rd_en cycle
  psum_buffer #(.IMAGE_SIZE(IMAGE_SIZE)) psum_i (
    .clk    (clk),
    .rd_addr(cur_tag.pixel_idx),
    .rd_data(stored_sum),
    .wr_en  (wb_en),
    .wr_addr(wb_addr),
    .wr_data(wb_data)
  );

  channel_accumulator acc_i (
    .clk       (clk),
    .reset     (reset),
    .pix_beat  (rd_beat),
    .tag       (rd_tag),
    .stored_sum(stored_sum),
    .wr_en     (wb_en),
    .wr_addr   (wb_addr),
    .wr_data   (wb_data),
    .valid_out (valid_out),
    .pxl_out   (pxl_out)
  );

endmodule

/* channel_in_adder_chk.sv */
module channel_in_adder_chk #(
  parameter int IMAGE_SIZE = 16
) (
  input logic                   clk,
  input logic                   reset,
  input logic                   valid_in,
  input conv_pkg::pixel_idx_t   fifo_count,
  input logic                   rd_en,
  input conv_pkg::seq_state_t   state,
  input logic                   valid_out
);
  timeunit 1ns;
  timeprecision 100ps;
  import conv_pkg::*;

  localparam int FIFO_DEPTH = 2 * IMAGE_SIZE;

  // No write may land on a full frame buffer
  fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
    !(valid_in && (fifo_count == pixel_idx_t'(FIFO_DEPTH))))
    else $error("frame FIFO written while full");

  output_low_after_reset: assert property (@(posedge clk) reset |=> !valid_out)
    else $error("valid_out high in the cycle after reset");

  // A burst opens only from idle once a whole frame is buffered
  burst_start_from_idle: assert property (@(posedge clk) disable iff (reset)
    $rose(rd_en) |->
      $past((state == SEQ_IDLE) && (fifo_count >= pixel_idx_t'(IMAGE_SIZE))))
    else $error("read burst started without a full frame while idle");

endmodule

bind channel_in_adder channel_in_adder_chk #(.IMAGE_SIZE(IMAGE_SIZE)) chk_i (
  .clk       (clk),
  .reset     (reset),
  .valid_in  (valid_in),
  .fifo_count(fifo_count),
  .rd_en     (rd_en),
  .state     (seq_i.state),
  .valid_out (valid_out)
);

/* tb_clock.sv */
module tb_clock #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

/* tb_channel_in_adder.sv */
module tb_channel_in_adder;
  timeunit 1ns;
  timeprecision 100ps;
  import conv_pkg::*;

  localparam int IMAGE_SIZE    = 16;
  localparam int CHANNEL_NUM   = 4;
  localparam int GROUP_NUM     = 5;
  localparam int EXTREME_GROUP = 2;
  localparam int WAIT_LIMIT    = 4000;

  logic        clk;
  logic        reset;
  logic        valid_in;
  pixel_t      pxl_in;
  logic        valid_out;
  sum_t        pxl_out;
  logic [31:0] rng_state;
  sum_t        expected_q [$];
  int          model_sum [IMAGE_SIZE];
  int          beats_total = 0;
  int          beats_in_group = 0;
  int          groups_done = 0;

  tb_clock #(.PERIOD_NS(8)) clock_i (.clk(clk));

  channel_in_adder #(
    .IMAGE_SIZE (IMAGE_SIZE),
    .CHANNEL_NUM(CHANNEL_NUM)
  ) dut_i (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .valid_out(valid_out),
    .pxl_out  (pxl_out)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                                  name, got, expected));
    end
  endtask

  // One pixel per call, held for a single clock
  task automatic send_pixel(input pixel_t value);
    valid_in = 1'b1;
    pxl_in   = value;
    @(posedge clk);
    #1;
    valid_in = 1'b0;
    pxl_in   = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Sends CHANNEL_NUM frames and queues the per-pixel channel sums
  task automatic send_group(input int group, input bit back_to_back);
    logic [31:0] r;
    pixel_t      value;
    for (int p = 0; p < IMAGE_SIZE; p++) begin
      model_sum[p] = 0;
    end
    for (int ch = 0; ch < CHANNEL_NUM; ch++) begin
      for (int p = 0; p < IMAGE_SIZE; p++) begin
        r = draw_random();
        if (group == EXTREME_GROUP) begin
          value = (p % 2 == 1) ? pixel_t'(16'h8000) : pixel_t'(16'h7fff);
        end else begin
          value = pixel_t'(r[15:0]);
        end
        model_sum[p] += int'(value);
        if (!back_to_back) begin
          idle_cycles(int'(r[25:24]));
        end
        send_pixel(value);
      end
    end
    for (int p = 0; p < IMAGE_SIZE; p++) begin
      expected_q.push_back(sum_t'(model_sum[p]));
    end
  endtask

  task automatic wait_for_groups(input int target);
    int cycles;
    cycles = 0;
    while ((groups_done < target) && (cycles < WAIT_LIMIT)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (groups_done < target) begin
      stop_with_failure($sformatf("Timeout: group %0d gave no full output frame in %0d cycles",
                                  groups_done, WAIT_LIMIT));
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  // Sampled mid-cycle, away from the active edge
  always @(negedge clk) begin
    if (reset) begin
      if (valid_out !== 1'b0) begin
        stop_with_failure("valid_out went high during reset");
      end
    end else if (valid_out === 1'b1) begin
      if (expected_q.size() == 0) begin
        stop_with_failure("valid_out high while no finished group was pending");
      end
      compare_value("pxl_out", 32'(pxl_out), 32'(expected_q.pop_front()));
      beats_total++;
      beats_in_group++;
      if (beats_in_group == IMAGE_SIZE) begin
        groups_done++;
        beats_in_group = 0;
      end
    end else if (beats_in_group != 0) begin
      stop_with_failure($sformatf("Output frame broke off after %0d of %0d beats",
                                  beats_in_group, IMAGE_SIZE));
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    rng_state = 32'h4f54;
    reset     = 1'b1;
    valid_in  = 1'b0;
    pxl_in    = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // First two groups without a single idle cycle
    send_group(0, 1'b1);
    send_group(1, 1'b1);
    wait_for_groups(2);
    for (int g = 2; g < GROUP_NUM; g++) begin
      send_group(g, 1'b0);
      wait_for_groups(g + 1);
    end

    // Stray beats would show up here
    idle_cycles(4 * IMAGE_SIZE);
    compare_value("beat_count", beats_total, GROUP_NUM * IMAGE_SIZE);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* compile.f */
conv_pkg.sv
frame_fifo.sv
psum_buffer.sv
pixel_channel_counter.sv
channel_sequencer.sv
channel_accumulator.sv
channel_in_adder.sv
channel_in_adder_chk.sv
tb_clock.sv
tb_channel_in_adder.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the channel_in_adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_channel_in_adder -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
